// ==== Makefile ====
# Verilator build and run for the execution stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ^RESULT: PASS$$

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
+incdir+src
src/isa_pkg.sv
src/expipe_pkg.sv
src/issue_dispatch.sv
src/alu_exec_unit.sv
src/cdb_arbiter.sv
src/exec_stage.sv
tests/exec_stage_assertions.sv
tests/tb_exec_stage.sv

// ==== src/alu_exec_unit.sv ====
/*
 * ALU execution unit.
 * One-entry reservation station with CDB operand wakeup, an integer
 * ALU and a result register held until the CDB takes it.
 */
`timescale 1ns/10ps
`include "exec_consts.svh"

module alu_exec_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,

  // from the dispatcher
  input  logic                   load_i,
  input  expipe_pkg::issue_req_t req_i,

  // CDB broadcast, for wakeup and release
  input  logic                   cdb_xfer_i,
  input  expipe_pkg::cdb_data_t  cdb_data_i,
  input  logic                   grant_i,

  // status and result
  output logic                   busy_o,
  output logic                   done_o,
  output expipe_pkg::cdb_data_t  result_o
);

  import isa_pkg::*;
  import expipe_pkg::*;

  // ----------------------------------------------------------------------
  // state and storage
  // ----------------------------------------------------------------------
  eu_state_e  state_q;
  issue_req_t req_q;      // stored instruction and operands
  word_t      res_q;      // computed result
  word_t      alu_res;
  logic       ops_ready;
  logic [4:0] shamt;

  // both stored operands present
  assign ops_ready = req_q.rs1.ready && req_q.rs2.ready;

  // ----------------------------------------------------------------------
  // ALU datapath
  // ----------------------------------------------------------------------
  // shifts only look at the low 5 bits
  assign shamt = req_q.rs2.value[4:0];

  always_comb begin
    alu_res = '0;
    case (req_q.op)
      ADD: alu_res = req_q.rs1.value + req_q.rs2.value;
      SUB: alu_res = req_q.rs1.value - req_q.rs2.value;
      AND: alu_res = req_q.rs1.value & req_q.rs2.value;
      OR:  alu_res = req_q.rs1.value | req_q.rs2.value;
      XOR: alu_res = req_q.rs1.value ^ req_q.rs2.value;
      SLL: alu_res = req_q.rs1.value << shamt;
      SRL: alu_res = req_q.rs1.value >> shamt;
      SLT: begin
        // signed compare, zero-extended flag
        alu_res[0] = $signed(req_q.rs1.value) < $signed(req_q.rs2.value);
      end
      default: alu_res = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else if (flush_i) begin
      // drop whatever is in flight
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (load_i) begin
            state_q <= WAIT_OPS;
          end
        end
        WAIT_OPS: begin
          // result registered on the same edge
          if (ops_ready) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // released only by its own accepted transfer
          if (grant_i && cdb_xfer_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      req_q <= req_i;
    end else if (state_q == WAIT_OPS) begin
      // wakeup from the broadcast, ready one edge later
      req_q.rs1 <= op_wakeup(req_q.rs1, cdb_xfer_i, cdb_data_i);
      req_q.rs2 <= op_wakeup(req_q.rs2, cdb_xfer_i, cdb_data_i);
      if (ops_ready) begin
        res_q <= alu_res;
      end
    end
  end

  // status towards dispatcher and arbiter
  assign busy_o           = (state_q != IDLE);
  assign done_o           = (state_q == DONE);
  assign result_o.rob_idx = req_q.rob_idx;
  assign result_o.value   = res_q;

endmodule

// ==== src/cdb_arbiter.sv ====
/*
 * CDB arbiter.
 * Round-robin pick among finished units, one result per transfer,
 * with the pick frozen while the bus is stalled.
 */
`timescale 1ns/10ps
`include "exec_consts.svh"

module cdb_arbiter (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  // from the units
  input  logic [`EXEC_EU_N-1:0]                  done_i,
  input  expipe_pkg::cdb_data_t [`EXEC_EU_N-1:0] results_i,

  // CDB port
  input  logic                                   cdb_ready_i,
  output logic [`EXEC_EU_N-1:0]                  grant_o,
  output logic                                   cdb_xfer_o,
  output logic                                   cdb_valid_o,
  output expipe_pkg::cdb_data_t                  cdb_data_o
);

  import expipe_pkg::*;

  localparam int unsigned IDX_W = (`EXEC_EU_N > 1) ? $clog2(`EXEC_EU_N) : 1;

  logic [IDX_W-1:0] ptr_q;       // first unit to consider
  logic [IDX_W-1:0] hold_idx_q;  // winner offered but not taken
  logic             hold_q;
  logic [IDX_W-1:0] rr_idx;
  logic [IDX_W-1:0] win_idx;
  logic             use_hold;

  // ----------------------------------------------------------------------
  // round-robin pick
  // ----------------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    logic        found;
    found  = 1'b0;
    rr_idx = ptr_q;
    for (int i = 0; i < `EXEC_EU_N; i++) begin
      cand = (int'(ptr_q) + i) % `EXEC_EU_N;
      if (!found && done_i[cand]) begin
        found  = 1'b1;
        rr_idx = IDX_W'(cand);
      end
    end
  end

  // stalled offer stays put, unless a flush emptied that unit
  assign use_hold = hold_q && done_i[hold_idx_q];
  assign win_idx  = use_hold ? hold_idx_q : rr_idx;

  // ----------------------------------------------------------------------
  // bus outputs
  // ----------------------------------------------------------------------
  assign cdb_valid_o = |done_i;
  assign cdb_data_o  = results_i[win_idx];
  assign cdb_xfer_o  = cdb_valid_o && cdb_ready_i;

  always_comb begin
    grant_o = '0;
    if (cdb_valid_o) begin
      grant_o[win_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // pointer and hold
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= cdb_valid_o && !cdb_ready_i;
      hold_idx_q <= win_idx;
      // step past the winner on each transfer
      if (cdb_xfer_o) begin
        if (win_idx == IDX_W'(`EXEC_EU_N - 1)) begin
          ptr_q <= '0;
        end else begin
          ptr_q <= win_idx + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/exec_consts.svh ====
/*
 * Execution stage constants.
 * Data width, ALU unit count and ROB tag width.
 */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// ----------------------------------------------------------------------
// datapath
// ----------------------------------------------------------------------
// integer data word width
`define EXEC_XLEN 32

// ----------------------------------------------------------------------
// execution resources
// ----------------------------------------------------------------------
// identical ALU units behind the dispatcher
`define EXEC_EU_N 4
// reorder buffer tag width
`define EXEC_ROB_IDX_W 4

`endif

// ==== src/exec_stage.sv ====
/*
 * Integer execution stage.
 * Issue dispatcher, a bank of ALU units and the CDB arbiter.
 */
`timescale 1ns/10ps
`include "exec_consts.svh"

module exec_stage (
  // clock, reset and flush
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,

  // issue port
  input  logic                   issue_valid_i,
  input  expipe_pkg::issue_req_t issue_req_i,
  output logic                   issue_ready_o,

  // CDB port
  input  logic                   cdb_ready_i,
  output logic                   cdb_valid_o,
  output expipe_pkg::cdb_data_t  cdb_data_o
);

  import expipe_pkg::*;

  // ----------------------------------------------------------------------
  // internal wiring
  // ----------------------------------------------------------------------
  logic [`EXEC_EU_N-1:0]      eu_busy;
  logic [`EXEC_EU_N-1:0]      eu_done;
  logic [`EXEC_EU_N-1:0]      eu_load;
  logic [`EXEC_EU_N-1:0]      eu_grant;
  issue_req_t                 eu_req;
  cdb_data_t [`EXEC_EU_N-1:0] eu_result;
  logic                       cdb_xfer;

  // dispatcher, patched request shared by all units
  issue_dispatch i_issue_dispatch (
    .issue_valid_i(issue_valid_i),
    .issue_req_i  (issue_req_i),
    .issue_ready_o(issue_ready_o),
    .eu_busy_i    (eu_busy),
    .cdb_xfer_i   (cdb_xfer),
    .cdb_data_i   (cdb_data_o),
    .eu_load_o    (eu_load),
    .eu_req_o     (eu_req)
  );

  // ALU bank
  for (genvar g = 0; g < `EXEC_EU_N; g++) begin : gen_alu_eu
    alu_exec_unit i_alu_exec_unit (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .flush_i   (flush_i),
      .load_i    (eu_load[g]),
      .req_i     (eu_req),
      .cdb_xfer_i(cdb_xfer),
      .cdb_data_i(cdb_data_o),
      .grant_i   (eu_grant[g]),
      .busy_o    (eu_busy[g]),
      .done_o    (eu_done[g]),
      .result_o  (eu_result[g])
    );
  end

  // result drain, also the wakeup broadcast
  cdb_arbiter i_cdb_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .done_i     (eu_done),
    .results_i  (eu_result),
    .cdb_ready_i(cdb_ready_i),
    .grant_o    (eu_grant),
    .cdb_xfer_o (cdb_xfer),
    .cdb_valid_o(cdb_valid_o),
    .cdb_data_o (cdb_data_o)
  );

endmodule

// ==== src/expipe_pkg.sv ====
/*
 * Execution pipeline transport types.
 * Operand tags, issue requests, CDB results and the unit state.
 */
`include "exec_consts.svh"

package expipe_pkg;

  // ----------------------------------------------------------------------
  // tags and operands
  // ----------------------------------------------------------------------
  // reorder buffer entry index
  typedef logic [`EXEC_ROB_IDX_W-1:0] rob_idx_t;

  // operand, either a value or the tag of its producer
  typedef struct packed {
    logic            ready;    // value field holds the operand
    rob_idx_t        rob_idx;  // producer tag while not ready
    isa_pkg::word_t  value;
  } op_data_t;

  // renamed instruction as it leaves the issue stage
  typedef struct packed {
    isa_pkg::alu_op_e op;
    op_data_t         rs1;
    op_data_t         rs2;
    rob_idx_t         rob_idx;  // destination entry
  } issue_req_t;

  // ----------------------------------------------------------------------
  // common data bus
  // ----------------------------------------------------------------------
  // one result broadcast per transfer
  typedef struct packed {
    rob_idx_t        rob_idx;
    isa_pkg::word_t  value;
  } cdb_data_t;

  // ALU unit occupancy
  typedef enum logic [1:0] {
    IDLE,
    WAIT_OPS,
    DONE
  } eu_state_e;

  // operand wakeup, takes the broadcast value on a tag match
  function automatic op_data_t op_wakeup(op_data_t op, logic xfer, cdb_data_t cdb);
    op_data_t res;
    res = op;
    if (xfer && !op.ready && (op.rob_idx == cdb.rob_idx)) begin
      res.ready = 1'b1;
      res.value = cdb.value;
    end
    return res;
  endfunction

endpackage

// ==== src/isa_pkg.sv ====
/*
 * ISA level types.
 * Integer ALU opcodes and the data word seen by the execution stage.
 */
`include "exec_consts.svh"

package isa_pkg;

  // ----------------------------------------------------------------------
  // data word
  // ----------------------------------------------------------------------
  // one architectural integer value
  typedef logic [`EXEC_XLEN-1:0] word_t;

  // ----------------------------------------------------------------------
  // ALU opcodes
  // ----------------------------------------------------------------------
  // 3-bit encoding carried by each issued instruction
  typedef enum logic [2:0] {
    ADD = 3'd0,  // rs1 + rs2
    SUB = 3'd1,  // rs1 - rs2
    AND = 3'd2,  // bitwise and
    OR  = 3'd3,  // bitwise or
    XOR = 3'd4,  // bitwise xor
    SLL = 3'd5,  // logical left shift, low 5 bits of rs2
    SRL = 3'd6,  // logical right shift, low 5 bits of rs2
    SLT = 3'd7   // signed less-than, result 0 or 1
  } alu_op_e;

endpackage

// ==== src/issue_dispatch.sv ====
/*
 * Issue dispatcher.
 * Steers each accepted instruction to the lowest idle ALU unit and
 * forwards same-cycle CDB results into its operands.
 */
`timescale 1ns/10ps
`include "exec_consts.svh"

module issue_dispatch (
  // issue port
  input  logic                   issue_valid_i,
  input  expipe_pkg::issue_req_t issue_req_i,
  output logic                   issue_ready_o,

  // unit occupancy
  input  logic [`EXEC_EU_N-1:0]  eu_busy_i,

  // CDB transfer of this cycle
  input  logic                   cdb_xfer_i,
  input  expipe_pkg::cdb_data_t  cdb_data_i,

  // to the units
  output logic [`EXEC_EU_N-1:0]  eu_load_o,
  output expipe_pkg::issue_req_t eu_req_o
);

  import expipe_pkg::*;

  // ----------------------------------------------------------------------
  // free unit selection
  // ----------------------------------------------------------------------
  logic [`EXEC_EU_N-1:0] free_sel;  // one-hot lowest idle unit

  always_comb begin
    free_sel = '0;
    // scan from the top so the lowest index wins
    for (int i = `EXEC_EU_N - 1; i >= 0; i--) begin
      if (!eu_busy_i[i]) begin
        free_sel    = '0;
        free_sel[i] = 1'b1;
      end
    end
  end

  // ready only from occupancy, never from valid
  assign issue_ready_o = |free_sel;

  // load strobe only on the handshake edge
  assign eu_load_o = (issue_valid_i && issue_ready_o) ? free_sel : '0;

  // ----------------------------------------------------------------------
  // same-cycle wakeup
  // ----------------------------------------------------------------------
  // producer broadcasting right now would be missed by the unit,
  // so patch the operands on the way in
  always_comb begin
    eu_req_o     = issue_req_i;
    eu_req_o.rs1 = op_wakeup(issue_req_i.rs1, cdb_xfer_i, cdb_data_i);
    eu_req_o.rs2 = op_wakeup(issue_req_i.rs2, cdb_xfer_i, cdb_data_i);
  end

endmodule

// ==== tests/exec_stage_assertions.sv ====
/*
 * Execution stage port assertions.
 * CDB hold under stall, quiet bus after flush, no issue when full.
 */
`timescale 1ns/10ps
`include "exec_consts.svh"

module exec_stage_assertions (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input logic                                   flush_i,
  input logic                                   issue_valid_i,
  input logic                                   issue_ready_o,
  input logic [`EXEC_EU_N-1:0]                  eu_busy_i,
  input expipe_pkg::cdb_data_t [`EXEC_EU_N-1:0] eu_result_i,
  input logic                                   cdb_ready_i,
  input logic                                   cdb_valid_o,
  input expipe_pkg::cdb_data_t                  cdb_data_o
);

  // ----------------------------------------------------------------------
  // CDB port
  // ----------------------------------------------------------------------
  // offer stays put until taken
  a_cdb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cdb_valid_o && !cdb_ready_i && !flush_i) |=> (cdb_valid_o && $stable(cdb_data_o)))
    else $error("CDB valid or data changed while stalled");

  // all units idle right after a flush
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !cdb_valid_o)
    else $error("CDB valid in the cycle after a flush");

  // ----------------------------------------------------------------------
  // issue port
  // ----------------------------------------------------------------------
  // refused offer leaves every busy unit with its own instruction
  for (genvar g = 0; g < `EXEC_EU_N; g++) begin : gen_no_issue_full
    a_no_issue_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (issue_valid_i && !issue_ready_o)
        |=> (!eu_busy_i[g] || $stable(eu_result_i[g].rob_idx)))
      else $error("ALU unit %0d took an instruction while issue ready was low", g);
  end

endmodule

bind exec_stage exec_stage_assertions i_exec_stage_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .flush_i      (flush_i),
  .issue_valid_i(issue_valid_i),
  .issue_ready_o(issue_ready_o),
  .eu_busy_i    (eu_busy),
  .eu_result_i  (eu_result),
  .cdb_ready_i  (cdb_ready_i),
  .cdb_valid_o  (cdb_valid_o),
  .cdb_data_o   (cdb_data_o)
);

// ==== tests/exec_stim.txt ====
# I op a_rdy a_idx a_val b_rdy b_idx b_val dst expected (hex), op 0..7 = ADD SUB AND OR XOR SLL SRL SLT
# F flushes, S n holds the CDB stalled for n cycles
I 0 1 0 00000005 1 0 00000007 0 0000000c
I 1 1 0 00000003 1 0 00000005 1 fffffffe
I 2 1 0 f0f0ff00 1 0 0ff0f0f0 2 00f0f000
I 3 1 0 12340000 1 0 00005678 3 12345678
I 4 1 0 aaaa5555 1 0 ffff0000 4 55555555
I 5 1 0 00000001 1 0 00000024 5 00000010
I 6 1 0 80000000 1 0 0000001f 6 00000001
I 7 1 0 ffffffff 1 0 00000001 7 00000001
I 7 1 0 00000002 1 0 fffffffe 8 00000000
# dependent chains
I 0 0 0 00000000 1 0 00000001 9 0000000d
I 0 1 0 00000100 1 0 00000020 a 00000120
I 1 0 a 00000000 1 0 00000020 b 00000100
I 4 0 b 00000000 0 a 00000000 c 00000020
# stall while issuing more than the unit count
S 8
I 0 1 0 00000001 1 0 00000001 d 00000002
I 0 1 0 00000002 1 0 00000002 e 00000004
I 0 0 d 00000000 0 e 00000000 f 00000006
I 6 1 0 00000100 1 0 00000004 0 00000010
I 2 0 f 00000000 1 0 0000000e 1 00000006
# flush with results held back
S 6
I 0 1 0 00000011 1 0 00000022 2 00000033
I 0 0 2 00000000 1 0 00000001 3 00000034
F
I 1 1 0 00000010 1 0 00000001 4 0000000f
I 3 0 4 00000000 1 0 000000f0 5 000000ff
I 7 0 5 00000000 1 0 00000100 6 00000001

// ==== tests/tb_exec_stage.sv ====
/*
 * Execution stage testbench.
 * Reads issue, flush and stall lines from the stim file, tracks
 * results by ROB index and checks every CDB transfer.
 */
`timescale 1ns/10ps
`include "exec_consts.svh"

module tb_exec_stage;

  import isa_pkg::*;
  import expipe_pkg::*;

  localparam int ROB_N = 1 << `EXEC_ROB_IDX_W;

  logic       clk_i;
  logic       rst_n_i;
  logic       flush_i;
  logic       issue_valid_i;
  issue_req_t issue_req_i;
  logic       issue_ready_o;
  logic       cdb_ready_i;
  logic       cdb_valid_o;
  cdb_data_t  cdb_data_o;

  // one entry per stim line
  byte        line_kind[$];
  issue_req_t line_req[$];
  word_t      line_exp[$];
  int         line_len[$];

  // scoreboard by ROB index
  logic       pending[ROB_N];
  logic       killed[ROB_N];
  word_t      rob_exp[ROB_N];
  int         pending_cnt;
  logic       issue_acc;
  int         cycle_cnt;
  int         cycle_limit;
  logic [31:0] rng_state;

  exec_stage i_exec_stage (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation aborted");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // rename hands a waiting operand the value of a producer that already left
  task automatic resolve_op(input op_data_t in_op, output op_data_t out_op);
    out_op = in_op;
    if (!in_op.ready && !pending[in_op.rob_idx]) begin
      if (killed[in_op.rob_idx]) begin
        abort_run($sformatf("stim operand waits on flushed ROB index %0d", in_op.rob_idx));
      end
      out_op.ready = 1'b1;
      out_op.value = rob_exp[in_op.rob_idx];
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    int          stall_sum;
    string       line;
    byte         kind;
    logic [31:0] op, ar, ai, av, br, bi, bv, dst, ex;
    issue_req_t  req;
    stall_sum = 0;
    fd = $fopen("tests/exec_stim.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stim file tests/exec_stim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 1 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      kind = line[0];
      req  = '0;
      ex   = '0;
      n    = 0;
      if (kind == "I") begin
        n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h",
                    kind, op, ar, ai, av, br, bi, bv, dst, ex);
        if (n != 10) begin
          abort_run($sformatf("malformed issue line in stim file: %s", line));
        end
        req.op          = alu_op_e'(op[2:0]);
        req.rs1.ready   = ar[0];
        req.rs1.rob_idx = ai[`EXEC_ROB_IDX_W-1:0];
        req.rs1.value   = av;
        req.rs2.ready   = br[0];
        req.rs2.rob_idx = bi[`EXEC_ROB_IDX_W-1:0];
        req.rs2.value   = bv;
        req.rob_idx     = dst[`EXEC_ROB_IDX_W-1:0];
      end else if (kind == "S") begin
        if ($sscanf(line, "%c %d", kind, n) != 2) begin
          abort_run($sformatf("malformed stall line in stim file: %s", line));
        end
        stall_sum += n;
      end else if (kind != "F") begin
        abort_run($sformatf("unknown line kind in stim file: %s", line));
      end
      line_kind.push_back(kind);
      line_req.push_back(req);
      line_exp.push_back(ex);
      line_len.push_back(n);
    end
    $fclose(fd);
    cycle_limit = 20 * line_kind.size() + stall_sum;
  endtask

  // ----------------------------------------------------------------------
  // CDB monitor sampled mid-cycle where everything is settled
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin : monitor_cdb
    int d;
    issue_acc = issue_valid_i && issue_ready_o;
    if (rst_n_i) begin
      // each in-flight result holds one unit up to its transfer edge
      check_eq(issue_ready_o, pending_cnt < `EXEC_EU_N, "issue ready vs units in flight");
    end
    if (rst_n_i && cdb_valid_o && cdb_ready_i) begin
      d = cdb_data_o.rob_idx;
      if (killed[d]) begin
        abort_run($sformatf("flushed ROB index %0d appeared on the CDB", d));
      end else if (!pending[d]) begin
        abort_run($sformatf("result for ROB index %0d not in flight", d));
      end else begin
        check_eq(cdb_data_o.value, rob_exp[d], $sformatf("ROB %0d result", d));
        pending[d] = 1'b0;
        pending_cnt--;
      end
    end
  end

  // run length guard
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles with %0d results outstanding",
                          cycle_cnt, pending_cnt));
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin : drive_seq
    int         li;
    int         stall_left;
    logic       issuing;
    logic       flush_edge;
    issue_req_t cur;
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    cdb_ready_i   = 1'b0;
    issue_acc     = 1'b0;
    rng_state     = 32'd11389;
    cycle_cnt     = 0;
    cycle_limit   = 1000;
    pending_cnt   = 0;
    for (int i = 0; i < ROB_N; i++) begin
      pending[i] = 1'b0;
      killed[i]  = 1'b0;
      rob_exp[i] = '0;
    end
    load_stim();
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    li         = 0;
    stall_left = 0;
    issuing    = 1'b0;
    flush_edge = 1'b0;
    while (li < line_kind.size() || issuing || pending_cnt != 0) begin
      @(posedge clk_i);
      // CDB back-pressure
      if (stall_left > 0) begin
        cdb_ready_i <= 1'b0;
        stall_left--;
      end else begin
        rng_state = xorshift32(rng_state);
        cdb_ready_i <= (rng_state[1:0] != 2'b00);
      end
      // everything still in flight at the flush edge is gone
      if (flush_edge) begin
        for (int i = 0; i < ROB_N; i++) begin
          if (pending[i]) begin
            pending[i] = 1'b0;
            killed[i]  = 1'b1;
            pending_cnt--;
          end
        end
        flush_i   <= 1'b0;
        flush_edge = 1'b0;
      end
      if (issuing && issue_acc) begin
        pending[cur.rob_idx] = 1'b1;
        killed[cur.rob_idx]  = 1'b0;
        pending_cnt++;
        issuing = 1'b0;
        issue_valid_i <= 1'b0;
        li++;
      end
      if (issuing) begin
        // producers may have finished while waiting
        resolve_op(line_req[li].rs1, cur.rs1);
        resolve_op(line_req[li].rs2, cur.rs2);
        issue_req_i <= cur;
      end else if (li < line_kind.size()) begin
        case (line_kind[li])
          "I": begin
            cur = line_req[li];
            // destination reuse waits for the older result
            if (!pending[cur.rob_idx]) begin
              resolve_op(line_req[li].rs1, cur.rs1);
              resolve_op(line_req[li].rs2, cur.rs2);
              rob_exp[cur.rob_idx] = line_exp[li];
              issue_req_i   <= cur;
              issue_valid_i <= 1'b1;
              issuing = 1'b1;
            end
          end
          "F": begin
            flush_i   <= 1'b1;
            flush_edge = 1'b1;
            li++;
          end
          default: begin
            stall_left = line_len[li];
            li++;
          end
        endcase
      end
    end
    // a stray flushed result would show up in the drain window
    cdb_ready_i <= 1'b1;
    repeat (5) @(posedge clk_i);
    check_eq(cdb_valid_o, 1'b0, "CDB idle at end");
    $display("RESULT: PASS");
    $finish;
  end

endmodule
